// File: sim.f
+incdir+.
isa_pkg.sv
dp_pkg.sv
register_file.sv
instr_decoder.sv
alu_writeback.sv
cpu_core.sv
cpu_core_chk.sv
tb_cpu_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_cpu_core -f sim.f -o tb_cpu_core

out=$(./obj_dir/tb_cpu_core 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx '=== PASS ==='; then
	exit 0
fi
echo "simulation did not report a pass" >&2
exit 1

// File: tb_cpu_core.sv
`include "cpu_cfg.svh"
`default_nettype none

module tb_cpu_core;

	timeunit 1ns;
	timeprecision 100ps;

	import isa_pkg::*;
	import dp_pkg::*;

	localparam int CLK_PERIOD      = 4;
	localparam int RESET_CYCLES    = 3;
	localparam int RANDOM_CYCLES   = 2000;
	localparam int DIRECTED_CYCLES = 44;
	localparam int DRAIN_CYCLES    = 8;
	localparam int SLACK_CYCLES    = 20;
	localparam int TIMEOUT_NS      =
		(RANDOM_CYCLES + DIRECTED_CYCLES + SLACK_CYCLES) * CLK_PERIOD;

	typedef struct packed {
		word_t     data;
		reg_addr_t rd;
		logic      z;
		int        due;
	} expect_t;

	logic      clk;
	logic      reset_n;
	logic      instr_valid;
	instr_t    instr;
	logic      result_valid;
	word_t     result;
	reg_addr_t result_reg;
	logic      zero;

	word_t     model_regs [`CPU_NUM_REGS];
	expect_t   exp_q [$];
	int        cycle;

	cpu_core cpu_core_i (
		.clk          (clk),
		.reset_n      (reset_n),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.result_valid (result_valid),
		.result       (result),
		.result_reg   (result_reg),
		.zero         (zero)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic abort_run();
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped after a failure");
	endtask

	task automatic check_word(string name, word_t exp, word_t act);
		if (act !== exp) begin
			$display("Error at time %0t: %s expected %h, got %h", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_reg(string name, reg_addr_t exp, reg_addr_t act);
		if (act !== exp) begin
			$display("Error at time %0t: %s expected %0d, got %0d", $time, name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_bit(string name, logic exp, logic act);
		if (act !== exp) begin
			$display("Error at time %0t: %s expected %b, got %b", $time, name, exp, act);
			abort_run();
		end
	endtask

	// reference ALU for the eight opcodes.
	function automatic word_t alu_model(opcode_t op, word_t a, word_t b, word_t imm);
		case (op)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_SHL:  return a << b[3:0];
			OP_MOV:  return a;
			default: return imm;
		endcase
	endfunction

	function automatic instr_t encode(opcode_t op, reg_addr_t rd, reg_addr_t rs1,
		reg_addr_t rs2);
		return {op, rd, rs1, rs2, 7'b0};
	endfunction

	function automatic instr_t encode_ldi(reg_addr_t rd, logic [7:0] imm);
		return {OP_LDI, rd, 2'b00, 1'b0, imm};
	endfunction

	// the model runs each instruction as it is issued; the result is due two
	// falling edges later.
	task automatic model_issue(instr_t word);
		opcode_t   op;
		reg_addr_t rd;
		reg_addr_t rs1;
		reg_addr_t rs2;
		word_t     imm;
		word_t     val;
		expect_t   e;
		op  = opcode_t'(word[15:13]);
		rd  = word[12:11];
		rs1 = word[10:9];
		rs2 = word[8:7];
		imm = {8'h00, word[7:0]};
		val = alu_model(op, model_regs[rs1], model_regs[rs2], imm);
		model_regs[rd] = val;
		e.data = val;
		e.rd   = rd;
		e.z    = (val == 16'h0000);
		e.due  = cycle + 2;
		exp_q.push_back(e);
	endtask

	task automatic check_outputs();
		logic    exp_valid;
		expect_t e;
		exp_valid = (exp_q.size() > 0) && (exp_q[0].due == cycle);
		check_bit("result_valid", exp_valid, result_valid);
		if (exp_valid) begin
			e = exp_q.pop_front();
			check_word("result", e.data, result);
			check_reg("result_reg", e.rd, result_reg);
			check_bit("zero", e.z, zero);
		end
	endtask

	task automatic next_cycle();
		@(negedge clk);
		cycle++;
		check_outputs();
	endtask

	task automatic issue(instr_t word);
		next_cycle();
		instr_valid = 1'b1;
		instr       = word;
		model_issue(word);
	endtask

	task automatic hold_reset();
		reset_n     = 1'b0;
		instr_valid = 1'b0;
		for (int r = 0; r < `CPU_NUM_REGS; r++) begin
			model_regs[r] = WORD_ZERO;
		end
		exp_q.delete();
		repeat (RESET_CYCLES) next_cycle();
		reset_n = 1'b1;
	endtask

	task automatic read_all_regs();
		for (int r = 0; r < `CPU_NUM_REGS; r++) begin
			issue(encode(OP_MOV, reg_addr_t'(r), reg_addr_t'(r), 2'd0));
		end
	endtask

	task automatic load_and_move();
		for (int r = 0; r < `CPU_NUM_REGS; r++) begin
			issue(encode_ldi(reg_addr_t'(r), 8'($urandom)));
			issue(encode(OP_MOV, reg_addr_t'(r), reg_addr_t'(r), 2'd0));
		end
	endtask

	// the registers hold nonzero words when reset hits, and the last load
	// is still in flight.
	task automatic load_before_reset();
		for (int r = 0; r < `CPU_NUM_REGS; r++) begin
			issue(encode_ldi(reg_addr_t'(r), 8'h80 | 8'(r)));
		end
	endtask

	// each instruction reads what the one right before it wrote.
	task automatic dependent_chain();
		issue(encode_ldi(2'd0, 8'hff));
		issue(encode(OP_ADD, 2'd1, 2'd0, 2'd0));
		issue(encode(OP_SUB, 2'd2, 2'd1, 2'd0));
		issue(encode(OP_XOR, 2'd3, 2'd2, 2'd1));
		issue(encode(OP_SHL, 2'd0, 2'd3, 2'd2));
		issue(encode(OP_SUB, 2'd1, 2'd0, 2'd0));
		issue(encode(OP_OR, 2'd1, 2'd1, 2'd3));
	endtask

	task automatic random_phase(int n);
		for (int i = 0; i < n; i++) begin
			logic   v;
			instr_t w;
			v = (($urandom % 4) != 0);
			w = instr_t'($urandom);
			next_cycle();
			instr_valid = v;
			instr       = w;
			if (v) begin
				model_issue(w);
			end
		end
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("watchdog expired before the test sequence completed");
		abort_run();
	end

	initial begin
		void'($urandom(39191));
		cycle       = 0;
		reset_n     = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		hold_reset();

		read_all_regs();
		load_and_move();
		dependent_chain();
		random_phase(RANDOM_CYCLES / 2);

		// reset in the middle of traffic; in-flight results are dropped.
		load_before_reset();
		next_cycle();
		hold_reset();
		read_all_regs();
		random_phase(RANDOM_CYCLES / 2);

		for (int i = 0; i < DRAIN_CYCLES; i++) begin
			next_cycle();
			instr_valid = 1'b0;
		end

		if (exp_q.size() == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			$display("%0d expected results never appeared", exp_q.size());
			abort_run();
		end
	end

endmodule

`default_nettype wire

// File: cpu_core_chk.sv
`default_nettype none

module cpu_core_chk (
	input logic          clk,
	input logic          reset_n,
	input logic          instr_valid,
	input logic          result_valid,
	input logic          reg_write,
	input logic          zero,
	input dp_pkg::word_t result
);

	timeunit 1ns;
	timeprecision 100ps;

	import dp_pkg::*;

	// an accepted instruction shows up as a result two sampling edges later.
	a_result_follows: assert property (@(posedge clk) disable iff (!reset_n)
		instr_valid |-> ##2 result_valid)
		else $error("result_valid missing two cycles after instr_valid");

	// and no result appears without an instruction behind it.
	a_no_spurious: assert property (@(posedge clk) disable iff (!reset_n)
		result_valid |-> $past(instr_valid, 2))
		else $error("result_valid without a matching instr_valid");

	a_reset_quiet: assert property (@(posedge clk)
		!reset_n |=> (!result_valid && !reg_write))
		else $error("result_valid or reg_write active during reset");

	a_zero_flag: assert property (@(posedge clk) disable iff (!reset_n)
		result_valid |-> (zero == (result == WORD_ZERO)))
		else $error("zero flag disagrees with result");

endmodule

bind cpu_core cpu_core_chk cpu_core_chk_i (
	.clk          (clk),
	.reset_n      (reset_n),
	.instr_valid  (instr_valid),
	.result_valid (result_valid),
	.reg_write    (reg_write),
	.zero         (zero),
	.result       (result)
);

`default_nettype wire

// File: cpu_core.sv
`default_nettype none

module cpu_core (
	input  logic              clk,
	input  logic              reset_n,
	input  logic              instr_valid,
	input  isa_pkg::instr_t   instr,
	output logic              result_valid,
	output dp_pkg::word_t     result,
	output dp_pkg::reg_addr_t result_reg,
	output logic              zero
);

	import isa_pkg::*;
	import dp_pkg::*;

	reg_addr_t rs1_addr;
	reg_addr_t rs2_addr;
	word_t     read_out1;
	word_t     read_out2;

	logic      dec_valid;
	opcode_t   dec_op;
	reg_addr_t dec_rd;
	word_t     dec_imm;

	logic      reg_write;
	reg_addr_t write_reg;
	word_t     write_data;

	// the operand read runs beside the decoder, straight from the raw word.
	assign rs1_addr = instr_rs1(instr);
	assign rs2_addr = instr_rs2(instr);

	register_file register_file_i (
		.clk        (clk),
		.reset_n    (reset_n),
		.read1      (rs1_addr),
		.read2      (rs2_addr),
		.write_reg  (write_reg),
		.write_data (write_data),
		.reg_write  (reg_write),
		.read_out1  (read_out1),
		.read_out2  (read_out2)
	);

	instr_decoder instr_decoder_i (
		.clk         (clk),
		.reset_n     (reset_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.dec_valid   (dec_valid),
		.dec_op      (dec_op),
		.dec_rd      (dec_rd),
		.dec_imm     (dec_imm)
	);

	alu_writeback alu_writeback_i (
		.clk          (clk),
		.reset_n      (reset_n),
		.dec_valid    (dec_valid),
		.dec_op       (dec_op),
		.dec_rd       (dec_rd),
		.dec_imm      (dec_imm),
		.opa          (read_out1),
		.opb          (read_out2),
		.reg_write    (reg_write),
		.write_reg    (write_reg),
		.write_data   (write_data),
		.result_valid (result_valid),
		.result       (result),
		.result_reg   (result_reg),
		.zero         (zero)
	);

endmodule

`default_nettype wire

// File: alu_writeback.sv
`include "cpu_cfg.svh"
`default_nettype none

module alu_writeback (
	input  logic              clk,
	input  logic              reset_n,
	input  logic              dec_valid,
	input  isa_pkg::opcode_t  dec_op,
	input  dp_pkg::reg_addr_t dec_rd,
	input  dp_pkg::word_t     dec_imm,
	input  dp_pkg::word_t     opa,
	input  dp_pkg::word_t     opb,
	output logic              reg_write,
	output dp_pkg::reg_addr_t write_reg,
	output dp_pkg::word_t     write_data,
	output logic              result_valid,
	output dp_pkg::word_t     result,
	output dp_pkg::reg_addr_t result_reg,
	output logic              zero
);

	import isa_pkg::*;
	import dp_pkg::*;

	localparam int SHAMT_W = $clog2(`CPU_DATA_W);

	word_t              alu_out;
	logic [SHAMT_W-1:0] shamt;
	logic               alu_zero;

	// shift left uses only the low bits of the second operand.
	assign shamt = opb[SHAMT_W-1:0];

	always_comb begin
		alu_out = WORD_ZERO;
		case (dec_op)
			OP_ADD: alu_out = opa + opb;
			OP_SUB: alu_out = opa - opb;
			OP_AND: alu_out = opa & opb;
			OP_OR:  alu_out = opa | opb;
			OP_XOR: alu_out = opa ^ opb;
			OP_SHL: alu_out = opa << shamt;
			OP_MOV: alu_out = opa;
			OP_LDI: alu_out = dec_imm;
			default: alu_out = WORD_ZERO;
		endcase
	end

	assign alu_zero = (alu_out == WORD_ZERO);

	// the write port is driven in the same cycle the operands arrive.
	// the register file picks it up at the next rising edge.
	assign reg_write  = dec_valid;
	assign write_reg  = dec_rd;
	assign write_data = alu_out;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= dec_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			result     <= WORD_ZERO;
			result_reg <= '0;
			zero       <= 1'b0;
		end else if (dec_valid) begin
			result     <= alu_out;
			result_reg <= dec_rd;
			zero       <= alu_zero;
		end
	end

endmodule

`default_nettype wire

// File: instr_decoder.sv
`default_nettype none

module instr_decoder (
	input  logic              clk,
	input  logic              reset_n,
	input  logic              instr_valid,
	input  isa_pkg::instr_t   instr,
	output logic              dec_valid,
	output isa_pkg::opcode_t  dec_op,
	output dp_pkg::reg_addr_t dec_rd,
	output dp_pkg::word_t     dec_imm
);

	import isa_pkg::*;
	import dp_pkg::*;

	opcode_t   op_field;
	reg_addr_t rd_field;
	word_t     imm_ext;

	assign op_field = instr_op(instr);
	assign rd_field = instr_rd(instr);

	// the 8-bit immediate is zero extended to a full word.
	assign imm_ext = word_t'(instr_imm8(instr));

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= instr_valid;
		end
	end

	// fields are captured every cycle; dec_valid says whether they matter.
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			dec_op  <= OP_ADD;
			dec_rd  <= '0;
			dec_imm <= WORD_ZERO;
		end else begin
			dec_op  <= op_field;
			dec_rd  <= rd_field;
			dec_imm <= imm_ext;
		end
	end

endmodule

`default_nettype wire

// File: register_file.sv
`include "cpu_cfg.svh"
`default_nettype none

module register_file (
	input  logic              clk,
	input  logic              reset_n,
	input  dp_pkg::reg_addr_t read1,
	input  dp_pkg::reg_addr_t read2,
	input  dp_pkg::reg_addr_t write_reg,
	input  dp_pkg::word_t     write_data,
	input  logic              reg_write,
	output dp_pkg::word_t     read_out1,
	output dp_pkg::word_t     read_out2
);

	import dp_pkg::*;

	word_t regs [`CPU_NUM_REGS];

	// a read of the register being written this cycle returns the new word,
	// so the instruction right behind a writer sees its result.
	function automatic word_t read_port(reg_addr_t addr);
		if (reg_write && (write_reg == addr)) begin
			return write_data;
		end
		return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < `CPU_NUM_REGS; i++) begin
				regs[i] <= WORD_ZERO;
			end
		end else if (reg_write) begin
			regs[write_reg] <= write_data;
		end
	end

	// both ports read every cycle, whether or not an instruction is present.
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			read_out1 <= WORD_ZERO;
			read_out2 <= WORD_ZERO;
		end else begin
			read_out1 <= read_port(read1);
			read_out2 <= read_port(read2);
		end
	end

endmodule

`default_nettype wire

// File: dp_pkg.sv
`include "cpu_cfg.svh"
`default_nettype none

package dp_pkg;

	// one data word as held in a register or carried on a result.
	typedef logic [`CPU_DATA_W-1:0] word_t;

	// index of a register in the register file.
	typedef logic [`CPU_REG_AW-1:0] reg_addr_t;

	// the all-zero word that clears registers and outputs.
	localparam word_t WORD_ZERO = '0;

endpackage

`default_nettype wire

// File: isa_pkg.sv
`include "cpu_cfg.svh"
`default_nettype none

package isa_pkg;

	typedef logic [`CPU_DATA_W-1:0] instr_t;

	typedef enum logic [`CPU_OP_W-1:0] {
		OP_ADD = 3'd0,
		OP_SUB = 3'd1,
		OP_AND = 3'd2,
		OP_OR  = 3'd3,
		OP_XOR = 3'd4,
		OP_SHL = 3'd5,
		OP_MOV = 3'd6,
		OP_LDI = 3'd7
	} opcode_t;

	// bit positions of the instruction fields.
	localparam int OP_MSB  = 15;
	localparam int OP_LSB  = 13;
	localparam int RD_MSB  = 12;
	localparam int RD_LSB  = 11;
	localparam int RS1_MSB = 10;
	localparam int RS1_LSB = 9;
	localparam int RS2_MSB = 8;
	localparam int RS2_LSB = 7;

	// the immediate shares bit 7 with rs2; only LDI looks at it.
	localparam int IMM_MSB = 7;
	localparam int IMM_LSB = 0;
	localparam int IMM_W   = IMM_MSB - IMM_LSB + 1;

	function automatic opcode_t instr_op(instr_t i);
		return opcode_t'(i[OP_MSB:OP_LSB]);
	endfunction

	function automatic logic [`CPU_REG_AW-1:0] instr_rd(instr_t i);
		return i[RD_MSB:RD_LSB];
	endfunction

	function automatic logic [`CPU_REG_AW-1:0] instr_rs1(instr_t i);
		return i[RS1_MSB:RS1_LSB];
	endfunction

	function automatic logic [`CPU_REG_AW-1:0] instr_rs2(instr_t i);
		return i[RS2_MSB:RS2_LSB];
	endfunction

	function automatic logic [IMM_W-1:0] instr_imm8(instr_t i);
		return i[IMM_MSB:IMM_LSB];
	endfunction

endpackage

`default_nettype wire

// File: cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// width of a data word and of every register.
`define CPU_DATA_W 16

// the register file holds this many words.
`define CPU_NUM_REGS 4
`define CPU_REG_AW 2

// opcode field width in the instruction word.
`define CPU_OP_W 3

`endif
